// File: files.f
+incdir+include
hdl/fir_pkg.sv
hdl/fir_tap_if.sv
hdl/sample_delay_line.sv
hdl/mult23_12.sv
hdl/fir_adder_tree.sv
hdl/fir_top.sv
tb/fir_tb.sv

// File: Makefile
# simulator, its options, the top module and the file list
SIM      := verilator
OBJDIR   := obj_dir
SIMFLAGS := --binary --timing --Mdir $(OBJDIR)
TOP      := fir_tb
FILELIST := files.f

BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := SOME TESTS FAILED

# sources named in the file list plus the included header
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# the binary is rebuilt only when a source, the header or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

# a nonzero exit or the failure line in the log fails the run
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/fir_tb.sv
`timescale 1ns/10ps
`include "fir_macros.svh"

// testbench for the four-tap FIR
// a stimulus table covers the impulse response, extreme values and gaps in valid_i,
// then a random section keeps valid_i high on every cycle
// every accepted sample gets an expected result from a software model of
//   y = 23 * (x[n-1] + x[n-2]) - x[n] - x[n-3]
// together with the cycle on which valid_o has to show it
module fir_tb;

    import fir_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 8;
    localparam int TABLE_LEN    = 28;
    localparam int RAND_COUNT   = 100;
    localparam int DRAIN_MARGIN = 10;
    localparam int NUM_TESTS    = 5;

    // one row of the stimulus table
    // expected is only meaningful on rows with valid set
    typedef struct packed {
        sample_t sample;
        logic    valid;
        int      gap;
        acc_t    expected;
    } stim_t;

    // one result that the DUT still owes
    typedef struct packed {
        acc_t model;
        acc_t table_val;
        logic has_table;
        int   due;
    } pending_t;

    logic        clk;
    logic        rst_n;
    logic [11:0] sample;
    logic        valid;
    logic [18:0] result;
    logic        result_valid;

    // the table value travels with the sample so the monitor can pick it up
    logic        table_has_exp;
    acc_t        table_exp;

    stim_t       stim_table [TABLE_LEN];
    pending_t    pending_q [$];
    sample_t     model_hist [`NUM_TAPS];

    // counts falling edges, used to place each expected strobe in time
    int          cyc;
    int          check_count;
    int          error_count;
    int          tests_passed;
    int          test_errors_start;
    integer      seed;

    fir_top UUT (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .sample_i (sample),
        .valid_i  (valid),
        .result_o (result),
        .valid_o  (result_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic stim_t make_entry(input int s, input logic v, input int g, input int y);
        stim_t e;
        e.sample   = sample_t'(s);
        e.valid    = v;
        e.gap      = g;
        e.expected = acc_t'(y);
        return e;
    endfunction

    // expected values worked out by hand from the filter rule
    task automatic load_table();
        // impulse of 1 followed by zeros, history starts at zero
        stim_table[0]  = make_entry(1, 1'b1, 0, -1);
        stim_table[1]  = make_entry(0, 1'b1, 0, 23);
        stim_table[2]  = make_entry(0, 1'b1, 0, 23);
        stim_table[3]  = make_entry(0, 1'b1, 0, -1);
        stim_table[4]  = make_entry(0, 1'b1, 0, 0);
        // extremes, rows 9 and 11 hit the largest negative and positive results
        stim_table[5]  = make_entry(2047, 1'b1, 0, -2047);
        stim_table[6]  = make_entry(2047, 1'b1, 0, 45034);
        stim_table[7]  = make_entry(-2048, 1'b1, 0, 96210);
        stim_table[8]  = make_entry(-2048, 1'b1, 0, -22);
        stim_table[9]  = make_entry(2047, 1'b1, 0, -98302);
        stim_table[10] = make_entry(2047, 1'b1, 0, -22);
        stim_table[11] = make_entry(-2048, 1'b1, 0, 98258);
        stim_table[12] = make_entry(-1, 1'b1, 0, -2069);
        stim_table[13] = make_entry(-1, 1'b1, 0, -49173);
        stim_table[14] = make_entry(0, 1'b1, 0, 2002);
        stim_table[15] = make_entry(0, 1'b1, 0, -22);
        stim_table[16] = make_entry(0, 1'b1, 0, 1);
        stim_table[17] = make_entry(0, 1'b1, 0, 0);
        // gaps, the rows with valid low carry samples that must not enter the history
        stim_table[18] = make_entry(5, 1'b1, 2, -5);
        stim_table[19] = make_entry(999, 1'b0, 0, 0);
        stim_table[20] = make_entry(-7, 1'b1, 3, 122);
        stim_table[21] = make_entry(100, 1'b1, 1, -146);
        stim_table[22] = make_entry(-300, 1'b0, 1, 0);
        stim_table[23] = make_entry(-3, 1'b1, 0, 2137);
        stim_table[24] = make_entry(0, 1'b1, 4, 2238);
        stim_table[25] = make_entry(0, 1'b1, 0, -169);
        stim_table[26] = make_entry(0, 1'b1, 0, 3);
        stim_table[27] = make_entry(0, 1'b1, 0, 0);
    endtask

    // software model of the filter, shifts its own history on each accepted sample
    task automatic model_accept(input sample_t s, output acc_t y);
        int sum;
        for (int i = `NUM_TAPS - 1; i > 0; i--) begin
            model_hist[i] = model_hist[i-1];
        end
        model_hist[0] = s;
        sum = 23 * (int'(model_hist[1]) + int'(model_hist[2]))
            - int'(model_hist[0]) - int'(model_hist[3]);
        y = acc_t'(sum);
    endtask

    task automatic check_acc(input acc_t actual, input acc_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s: result_o is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_strobe(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s: valid_o is %b, expected %b",
                     $time, what, actual, expected);
        end
    endtask

    // outputs are looked at on the falling edge, half a cycle away from any change
    // a result leaves the queue only when valid_o actually shows it
    always @(negedge clk) begin
        pending_t head;
        pending_t item;
        acc_t     y;
        cyc = cyc + 1;
        if (pending_q.size() > 0) begin
            head = pending_q[0];
            check_strobe(result_valid, head.due == cyc, "valid_o three edges after its sample");
            if (result_valid === 1'b1) begin
                check_acc(acc_t'(result), head.model, "result against the model");
                if (head.has_table) begin
                    check_acc(acc_t'(result), head.table_val, "result against the table");
                end
                void'(pending_q.pop_front());
            end
        end else if (result_valid === 1'b1) begin
            check_count++;
            error_count++;
            $display("valid_o went high at %0t while no result was pending", $time);
        end else begin
            check_strobe(result_valid, 1'b0, "valid_o while no result is due");
        end
        // the sample seen here is taken by the next rising edge E,
        // so its result must show on the falling edge after E+3
        if (rst_n === 1'b1 && valid === 1'b1) begin
            model_accept(sample_t'(sample), y);
            item.model     = y;
            item.table_val = table_exp;
            item.has_table = table_has_exp;
            item.due       = cyc + 4;
            pending_q.push_back(item);
        end
    end

    // drives one table row, then holds valid_i low for the row's gap
    task automatic apply_entry(input stim_t e);
        @(posedge clk);
        sample        <= e.sample;
        valid         <= e.valid;
        table_has_exp <= e.valid;
        table_exp     <= e.expected;
        repeat (e.gap) begin
            @(posedge clk);
            valid         <= 1'b0;
            table_has_exp <= 1'b0;
        end
    endtask

    task automatic apply_random();
        integer rand_word;
        rand_word = $random(seed);
        @(posedge clk);
        sample        <= rand_word[`SAMPLE_W-1:0];
        valid         <= 1'b1;
        table_has_exp <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid         <= 1'b0;
            table_has_exp <= 1'b0;
        end
    endtask

    // stops the stream and waits until the DUT has shown every owed result
    // or the margin has run out
    task automatic drain_pipeline();
        int waited;
        idle_cycles(1);
        waited = 0;
        while (pending_q.size() > 0 && waited < DRAIN_MARGIN) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_errors_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
        end
        test_errors_start = error_count;
    endtask

    initial begin
        int idx;
        seed              = 32'h1a8d2373;
        rst_n             = 1'b0;
        sample            = '0;
        valid             = 1'b0;
        table_has_exp     = 1'b0;
        table_exp         = '0;
        cyc               = 0;
        check_count       = 0;
        error_count       = 0;
        tests_passed      = 0;
        test_errors_start = 0;
        for (int i = 0; i < `NUM_TAPS; i++) begin
            model_hist[i] = '0;
        end
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(IDLE_CYCLES);
        finish_test("reset and idle");

        for (idx = 0; idx < 5; idx++) begin
            apply_entry(stim_table[idx]);
        end
        drain_pipeline();
        finish_test("impulse response");

        for (idx = 5; idx < 18; idx++) begin
            apply_entry(stim_table[idx]);
        end
        drain_pipeline();
        finish_test("extreme values");

        for (idx = 18; idx < TABLE_LEN; idx++) begin
            apply_entry(stim_table[idx]);
        end
        drain_pipeline();
        finish_test("gaps in valid_i");

        // three samples are in flight at any time here
        for (idx = 0; idx < RAND_COUNT; idx++) begin
            apply_random();
        end
        drain_pipeline();
        finish_test("back-to-back random");

        if (pending_q.size() != 0) begin
            error_count++;
            $display("%0d expected results never appeared on valid_o", pending_q.size());
        end
        $display("tests passed: %0d of %0d, checks: %0d, errors: %0d",
                 tests_passed, NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the table, its gaps, the random run and the drains
    initial begin
        int gap_total;
        int limit_cycles;
        @(posedge clk);
        gap_total = 0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            gap_total += stim_table[i].gap;
        end
        limit_cycles = RESET_CYCLES + IDLE_CYCLES + TABLE_LEN + gap_total + RAND_COUNT
                     + NUM_TESTS * DRAIN_MARGIN + 20;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: hdl/fir_top.sv
`timescale 1ns/10ps

// four-tap symmetric FIR with fixed taps -1, 23, 23, -1
// accepts one 12-bit sample per valid_i strobe and returns one 19-bit result
// per sample, three edges after the edge that took the sample in
// nothing here can stall, so a sample may be offered on every cycle
//
// data flow:
//   sample_i -> delay line -> tap1, tap2 -> two multiply-by-23 blocks
//                          -> tap0, tap3 -----------------------------> adder tree
//   products -----------------------------------------------------------> adder tree
module fir_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [11:0] sample_i,
    input  logic        valid_i,
    output logic [18:0] result_o,
    output logic        valid_o
);

    import fir_pkg::*;

    // registered products of the two inner taps
    prod_t prod_tap1;
    prod_t prod_tap2;

    // shared sample history between the delay line and the adder tree
    fir_tap_if u_taps ();

    // history of the last four accepted samples
    sample_delay_line u_delay_line (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sample_i (sample_i),
        .valid_i  (valid_i),
        .taps     (u_taps)
    );

    // 23 * x[n-1]
    mult23_12 u_mult_tap1 (
        .clk_i (clk_i),
        .in_i  (u_taps.tap1),
        .out_o (prod_tap1)
    );

    // 23 * x[n-2]
    mult23_12 u_mult_tap2 (
        .clk_i (clk_i),
        .in_i  (u_taps.tap2),
        .out_o (prod_tap2)
    );

    // lines up the outer taps with the products and forms the final sum
    fir_adder_tree u_adder_tree (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .taps     (u_taps),
        .prod1_i  (prod_tap1),
        .prod2_i  (prod_tap2),
        .result_o (result_o),
        .valid_o  (valid_o)
    );

endmodule

// File: hdl/fir_adder_tree.sv
`timescale 1ns/10ps

// combines the weighted taps into the filter output
//   y = 23 * (tap1 + tap2) - tap0 - tap3
// the inner taps arrive already multiplied and registered, so the outer taps
// and the strobe are delayed one cycle first to line up with them
//
// pipeline, counted from the edge E that accepted a sample:
//   E+1  align tap0, tap3 and the strobe with the products
//   E+2  inner sum of the two products, outer sum of the two plain taps
//   E+3  difference into result_o, valid_o high for one cycle
module fir_adder_tree (
    input  logic           clk_i,
    input  logic           rst_n_i,
    fir_tap_if.consumer    taps,
    input  fir_pkg::prod_t prod1_i,
    input  fir_pkg::prod_t prod2_i,
    output fir_pkg::acc_t  result_o,
    output logic           valid_o
);

    import fir_pkg::*;

    // stage 1, outer taps held one cycle to match the multiplier latency
    sample_t tap0_d;
    sample_t tap3_d;
    logic    valid_d1;

    // stage 2, the two partial sums
    acc_t    inner_sum;
    acc_t    outer_sum;
    logic    valid_d2;

    // stage 1 data
    always_ff @(posedge clk_i) begin
        tap0_d <= taps.tap0;
        tap3_d <= taps.tap3;
    end

    // stage 2 data
    // both products and both taps are sign-extended to the full result width
    // before adding, which leaves room for the worst case of 23 * 2048 * 2
    always_ff @(posedge clk_i) begin
        inner_sum <= acc_t'(prod1_i) + acc_t'(prod2_i);
        outer_sum <= acc_t'(tap0_d) + acc_t'(tap3_d);
    end

    // stage 3 data
    // the outer taps carry a weight of minus one, so they are subtracted here
    always_ff @(posedge clk_i) begin
        result_o <= inner_sum - outer_sum;
    end

    // the strobe rides alongside the data through three registers
    // so valid_o marks the cycle in which result_o holds a fresh value
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_d1 <= taps.tap_valid;
            valid_d2 <= valid_d1;
            valid_o  <= valid_d2;
        end
    end

endmodule

// File: hdl/mult23_12.sv
`timescale 1ns/10ps
`include "fir_macros.svh"

// registered multiply of a 12-bit signed sample by the constant 23
// 23 is split as 16 + 8 - 1, and the minus one is done in two's complement,
// so the product is (x << 4) + (x << 3) + ~x + 1
//
// the logic is laid out the way a carry-chain mapping would want it:
//   bits 2:0  come straight from the input, since the shifted terms are zero there
//   bits 15:3 are one three-operand add with the low carry fed in at the bottom
//   bit 16    is the input sign, because 23 * 2047 never reaches bit 16
//             and every negative product has it set
// resource-wise this costs about as much as a 12-bit adder
module mult23_12 (
    input  logic             clk_i,
    input  fir_pkg::sample_t in_i,
    output fir_pkg::prod_t   out_o
);

    import fir_pkg::*;

    // sample sign-extended far enough for the top of the three-operand add
    logic [`PROD_W-2:0] in_ext;

    // the three low result bits and the carry they hand upward
    logic [2:0]         low_bits;
    logic               low_carry;

    // operands of the middle add, all aligned to result bit 3
    logic [12:0]        op_x16;
    logic [12:0]        op_x8;
    logic [12:0]        op_inv;

    // result bits 15:3
    logic [12:0]        mid_sum;

    assign in_ext = {{(`PROD_W - 1 - `SAMPLE_W){in_i[`SAMPLE_W-1]}}, in_i};

    // bit 0 is ~x[0] ^ 1, which is just x[0]
    assign low_bits[0] = in_i[0];

    // bit 1 gets the carry ~x[0] from bit 0, and ~a ^ ~b is a ^ b
    assign low_bits[1] = in_i[1] ^ in_i[0];

    // bit 2 only sees a carry when both lower inverted bits were set
    assign low_bits[2] = ~in_i[2] ^ ~|in_i[1:0];

    // the +1 ripples out of bit 2 only if x[2:0] was all zeros
    assign low_carry = ~|in_i[2:0];

    // x << 4 seen from bit 3 is x << 1, with a zero at the bottom
    assign op_x16 = {in_ext[11:0], 1'b0};

    // x << 3 seen from bit 3 is x itself
    assign op_x8 = in_ext[12:0];

    // the inverted input, upper part only
    assign op_inv = ~in_ext[15:3];

    // one ternary add with the low carry as carry-in
    // bits above 15 are dropped here and rebuilt from the sign
    assign mid_sum = op_x16 + op_x8 + op_inv + {12'd0, low_carry};

    // one register stage, no enable, so a new product is formed every cycle
    always_ff @(posedge clk_i) begin
        out_o <= {in_i[`SAMPLE_W-1], mid_sum, low_bits};
    end

endmodule

// File: hdl/sample_delay_line.sv
`timescale 1ns/10ps
`include "fir_macros.svh"

// shift register holding the last four accepted samples
// the history only moves when valid_i is high on a clock edge,
// so idle cycles between samples leave the taps untouched
module sample_delay_line (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  fir_pkg::sample_t sample_i,
    input  logic             valid_i,
    fir_tap_if.producer      taps
);

    import fir_pkg::*;

    // hist[0] is the newest sample, hist[NUM_TAPS-1] the oldest
    sample_t hist [`NUM_TAPS];

    // registered copy of the input strobe
    logic    tap_valid_q;

    // the history starts at zero so the first three results
    // behave as if zeros had been streamed in before them
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (valid_i) begin
            // everything moves one step older and the new sample lands at the front
            for (int i = `NUM_TAPS - 1; i > 0; i--) begin
                hist[i] <= hist[i-1];
            end
            hist[0] <= sample_i;
        end
    end

    // strobe is high for exactly the cycle after the accepting edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tap_valid_q <= 1'b0;
        end else begin
            tap_valid_q <= valid_i;
        end
    end

    // drive the shared tap bundle straight from the history registers
    assign taps.tap0      = hist[0];
    assign taps.tap1      = hist[1];
    assign taps.tap2      = hist[2];
    assign taps.tap3      = hist[3];
    assign taps.tap_valid = tap_valid_q;

endmodule

// File: hdl/fir_tap_if.sv
`timescale 1ns/10ps

// the four most recent accepted samples together with their strobe
// tap0 is the newest sample and tap3 the oldest
interface fir_tap_if;

    import fir_pkg::*;

    // sample history, newest first
    sample_t tap0;
    sample_t tap1;
    sample_t tap2;
    sample_t tap3;

    // high for one cycle after the history has shifted in a new sample
    logic tap_valid;

    // the delay line owns the history
    modport producer (
        output tap0,
        output tap1,
        output tap2,
        output tap3,
        output tap_valid
    );

    // the adder tree only reads it
    modport consumer (
        input tap0,
        input tap1,
        input tap2,
        input tap3,
        input tap_valid
    );

endinterface

// File: hdl/fir_pkg.sv
`include "fir_macros.svh"

package fir_pkg;

    // one input sample as it arrives on the stream
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // output of a multiply-by-23 block
    // bit 16 is always a copy of the sample sign
    typedef logic signed [`PROD_W-1:0] prod_t;

    // partial sums inside the adder tree and the final filter output
    typedef logic signed [`ACC_W-1:0] acc_t;

endpackage

// File: include/fir_macros.svh
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// width of one input sample in two's complement
`define SAMPLE_W 12

// width of a sample times 23, which needs five more bits than the sample
`define PROD_W 17

// width of the filter result
// the largest magnitude is 23 * 4096 + 4096, which fits in 19 signed bits
`define ACC_W 19

// the filter is fixed at four taps: -1, 23, 23, -1
`define NUM_TAPS 4

`endif
